//--- common/debug_params.svh
`ifndef DEBUG_PARAMS_SVH
`define DEBUG_PARAMS_SVH

// UART byte and data word
`define DU_DATA_W          8
`define DU_WORD_W          32
`define DU_BYTES_PER_WORD  4

// Instruction memory load
`define DU_IM_ADDR_W       32
`define DU_IM_BYTES        256

// Register bank dump
`define DU_RB_DEPTH        32
`define DU_RB_ADDR_W       5

// Data memory dump
`define DU_DM_DEPTH        32
`define DU_DM_ADDR_W       5

// Width of the state seen by the host side
`define DU_STATE_W         4

`endif

//--- common/debug_pkg.sv
`include "debug_params.svh"

package debug_pkg;

    typedef logic [`DU_DATA_W-1:0] byte_t;
    typedef logic [`DU_WORD_W-1:0] word_t;

    // Encodings are visible on o_state
    typedef enum logic [`DU_STATE_W-1:0] {
        ST_IDLE     = 1,
        ST_WRITE_IM = 2,
        ST_READY    = 4,
        ST_RUN      = 5,
        ST_STEP     = 6,
        ST_DUMP_RB  = 7,
        ST_DUMP_DM  = 8,
        ST_DUMP_PC  = 9
    } state_e;

    // One-byte host opcodes
    typedef enum logic [`DU_DATA_W-1:0] {
        CMD_WRITE_IM     = 1,
        CMD_START        = 2,
        CMD_STEP_BY_STEP = 3,
        CMD_SEND_RB      = 4,
        CMD_SEND_DM      = 5,
        CMD_SEND_PC      = 6,
        CMD_STEP         = 7,
        CMD_CONTINUE     = 8
    } command_e;

    typedef enum logic [1:0] {
        SRC_PC = 2'd0,
        SRC_RB = 2'd1,
        SRC_DM = 2'd2
    } dump_src_e;

endpackage

//--- design/program_loader.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module program_loader
    import debug_pkg::*;
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_start,
    input  logic                     i_rx_done,
    input  byte_t                    i_rx_data,
    output logic                     o_im_write_enable,
    output logic [`DU_IM_ADDR_W-1:0] o_im_addr,
    output byte_t                    o_im_data,
    output logic                     o_done
);

    localparam logic [`DU_IM_ADDR_W-1:0] LAST_ADDR = `DU_IM_ADDR_W'(`DU_IM_BYTES - 1);

    logic active;
    logic accept;

    // A byte may already arrive with the start pulse
    assign accept = (active || i_start) && i_rx_done;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            active            <= 1'b0;
            o_im_write_enable <= 1'b0;
            o_im_addr         <= '0;
            o_done            <= 1'b0;
        end else begin
            o_im_write_enable <= accept;
            o_done            <= 1'b0;
            if (i_start)
                active <= 1'b1;
            // Address moves on after its write pulse
            if (o_im_write_enable) begin
                if (o_im_addr == LAST_ADDR) begin
                    o_im_addr <= '0;
                    active    <= 1'b0;
                    o_done    <= 1'b1;
                end else begin
                    o_im_addr <= o_im_addr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (accept)
            o_im_data <= i_rx_data;
    end

endmodule

//--- debug_unit/command_fsm.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module command_fsm
    import debug_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_reset,
    input  logic      i_rx_done,
    input  byte_t     i_rx_data,
    input  logic      i_hlt,
    input  logic      i_load_done,
    input  logic      i_dump_done,
    output logic      o_load_start,
    output logic      o_dump_start,
    output dump_src_e o_dump_src,
    output logic      o_core_enable,
    output logic      o_step_flag,
    output logic      o_step,
    output state_e    o_state
);

    state_e    next_state;
    command_e  cmd;
    logic      chain;           // Dumps belong to a step
    logic      next_chain;
    logic      next_load_start;
    logic      next_dump_start;
    dump_src_e next_dump_src;
    logic      next_step;
    logic      next_step_mode;

    assign cmd = command_e'(i_rx_data);

    // Core stays enabled through the post-step dumps
    assign next_step_mode = (next_state == ST_STEP) || next_chain;

    always_comb begin
        next_state      = o_state;
        next_chain      = chain;
        next_load_start = 1'b0;
        next_dump_start = 1'b0;
        next_dump_src   = o_dump_src;
        next_step       = 1'b0;

        case (o_state)
            ST_IDLE: begin
                if (i_rx_done) begin
                    case (cmd)
                        CMD_WRITE_IM: begin
                            next_state      = ST_WRITE_IM;
                            next_load_start = 1'b1;
                        end
                        CMD_SEND_PC: begin
                            next_state      = ST_DUMP_PC;
                            next_dump_start = 1'b1;
                            next_dump_src   = SRC_PC;
                        end
                        CMD_SEND_RB: begin
                            next_state      = ST_DUMP_RB;
                            next_dump_start = 1'b1;
                            next_dump_src   = SRC_RB;
                        end
                        CMD_SEND_DM: begin
                            next_state      = ST_DUMP_DM;
                            next_dump_start = 1'b1;
                            next_dump_src   = SRC_DM;
                        end
                        default: ;      // Ignored in idle
                    endcase
                end
            end
            ST_WRITE_IM: begin
                if (i_load_done)
                    next_state = ST_READY;
            end
            ST_READY: begin
                if (i_rx_done) begin
                    case (cmd)
                        CMD_START:        next_state = ST_RUN;
                        CMD_STEP_BY_STEP: next_state = ST_STEP;
                        default: ;
                    endcase
                end
            end
            ST_RUN: begin
                if (i_hlt)
                    next_state = ST_IDLE;
            end
            ST_STEP: begin
                // Halt wins over a command in the same cycle
                if (i_hlt) begin
                    next_state = ST_IDLE;
                end else if (i_rx_done) begin
                    case (cmd)
                        CMD_STEP: begin
                            next_state      = ST_DUMP_PC;
                            next_chain      = 1'b1;
                            next_step       = 1'b1;
                            next_dump_start = 1'b1;
                            next_dump_src   = SRC_PC;
                        end
                        CMD_CONTINUE: next_state = ST_RUN;
                        default: ;
                    endcase
                end
            end
            ST_DUMP_PC: begin
                if (i_dump_done) begin
                    if (chain) begin
                        next_state      = ST_DUMP_DM;   // PC, then DM
                        next_dump_start = 1'b1;
                        next_dump_src   = SRC_DM;
                    end else begin
                        next_state = ST_IDLE;
                    end
                end
            end
            ST_DUMP_DM: begin
                if (i_dump_done) begin
                    if (chain) begin
                        next_state      = ST_DUMP_RB;   // DM, then RB
                        next_dump_start = 1'b1;
                        next_dump_src   = SRC_RB;
                    end else begin
                        next_state = ST_IDLE;
                    end
                end
            end
            ST_DUMP_RB: begin
                if (i_dump_done) begin
                    next_state = chain ? ST_STEP : ST_IDLE;
                    next_chain = 1'b0;
                end
            end
            default: begin
                next_state = ST_IDLE;
                next_chain = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_state       <= ST_IDLE;
            chain         <= 1'b0;
            o_load_start  <= 1'b0;
            o_dump_start  <= 1'b0;
            o_dump_src    <= SRC_PC;
            o_core_enable <= 1'b0;
            o_step_flag   <= 1'b0;
            o_step        <= 1'b0;
        end else begin
            o_state       <= next_state;
            chain         <= next_chain;
            o_load_start  <= next_load_start;
            o_dump_start  <= next_dump_start;
            o_dump_src    <= next_dump_src;
            o_core_enable <= (next_state == ST_RUN) || next_step_mode;
            o_step_flag   <= next_step_mode;
            o_step        <= next_step;       // One pulse per STEP byte
        end
    end

endmodule

//--- debug_unit/word_serializer.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module word_serializer
    import debug_pkg::*;
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_start,
    input  dump_src_e                i_src,
    input  logic                     i_tx_done,
    input  word_t                    i_pc_value,
    input  word_t                    i_rb_data,
    input  word_t                    i_dm_data,
    output logic                     o_tx_start,
    output byte_t                    o_tx_data,
    output logic                     o_rb_read_enable,
    output logic [`DU_RB_ADDR_W-1:0] o_rb_addr,
    output logic                     o_dm_read_enable,
    output logic                     o_dm_du_flag,
    output logic [`DU_DM_ADDR_W-1:0] o_dm_addr,
    output logic                     o_done
);

    localparam int IDX_W      = (`DU_RB_ADDR_W > `DU_DM_ADDR_W) ? `DU_RB_ADDR_W
                                                                : `DU_DM_ADDR_W;
    localparam int BYTE_IDX_W = $clog2(`DU_BYTES_PER_WORD);
    localparam logic [BYTE_IDX_W-1:0] LAST_BYTE = BYTE_IDX_W'(`DU_BYTES_PER_WORD - 1);

    logic                  active;
    dump_src_e             src;
    logic [IDX_W-1:0]      word_idx;
    logic [BYTE_IDX_W-1:0] byte_idx;
    logic [IDX_W-1:0]      last_word;
    logic                  last_byte_sent;
    word_t                 cur_word;
    byte_t                 cur_byte;

    // Last word index per source
    always_comb begin
        case (src)
            SRC_RB:  last_word = IDX_W'(`DU_RB_DEPTH - 1);
            SRC_DM:  last_word = IDX_W'(`DU_DM_DEPTH - 1);
            default: last_word = '0;    // PC is a single word
        endcase
    end

    always_comb begin
        case (src)
            SRC_RB:  cur_word = i_rb_data;
            SRC_DM:  cur_word = i_dm_data;
            default: cur_word = i_pc_value;
        endcase
    end

    // MSB first
    assign cur_byte = cur_word[(LAST_BYTE - byte_idx) * `DU_DATA_W +: `DU_DATA_W];

    assign last_byte_sent = active && i_tx_done && (byte_idx == LAST_BYTE)
                            && (word_idx == last_word);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            active     <= 1'b0;
            src        <= SRC_PC;
            word_idx   <= '0;
            byte_idx   <= '0;
            o_tx_start <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_done     <= last_byte_sent;
            o_tx_start <= active && !last_byte_sent;
            if (i_start) begin
                active   <= 1'b1;
                src      <= i_src;
                word_idx <= '0;
                byte_idx <= '0;
            end else if (active && i_tx_done) begin
                byte_idx <= byte_idx + 1'b1;    // Wraps after the LSB
                if (byte_idx == LAST_BYTE) begin
                    if (word_idx == last_word) begin
                        active   <= 1'b0;
                        word_idx <= '0;
                    end else begin
                        word_idx <= word_idx + 1'b1;
                    end
                end
            end
        end
    end

    // UART byte trails the counters by one cycle
    always_ff @(posedge i_clock) begin
        if (active)
            o_tx_data <= cur_byte;
    end

    assign o_rb_read_enable = active && (src == SRC_RB);
    assign o_dm_read_enable = active && (src == SRC_DM);
    assign o_dm_du_flag     = active && (src == SRC_DM);  // DM address from debug side
    assign o_rb_addr        = word_idx[`DU_RB_ADDR_W-1:0];
    assign o_dm_addr        = word_idx[`DU_DM_ADDR_W-1:0];

endmodule

//--- design/debug_unit_top.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module debug_unit_top
    import debug_pkg::*;
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_hlt,
    input  logic                     i_rx_done,
    input  byte_t                    i_rx_data,
    input  logic                     i_tx_done,
    input  word_t                    i_pc_value,
    input  word_t                    i_rb_data,
    input  word_t                    i_dm_data,
    output logic                     o_tx_start,
    output byte_t                    o_tx_data,
    output logic                     o_im_write_enable,
    output logic [`DU_IM_ADDR_W-1:0] o_im_addr,
    output byte_t                    o_im_data,
    output logic                     o_rb_read_enable,
    output logic [`DU_RB_ADDR_W-1:0] o_rb_addr,
    output logic                     o_dm_read_enable,
    output logic                     o_dm_du_flag,
    output logic [`DU_DM_ADDR_W-1:0] o_dm_addr,
    output logic                     o_core_enable,
    output logic                     o_step_flag,
    output logic                     o_step,
    output logic [`DU_STATE_W-1:0]   o_state
);

    logic      load_start;
    logic      load_done;
    logic      dump_start;
    logic      dump_done;
    dump_src_e dump_src;
    state_e    state;

    assign o_state = state;

    command_fsm command_fsm_inst (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_rx_done     (i_rx_done),
        .i_rx_data     (i_rx_data),
        .i_hlt         (i_hlt),
        .i_load_done   (load_done),
        .i_dump_done   (dump_done),
        .o_load_start  (load_start),
        .o_dump_start  (dump_start),
        .o_dump_src    (dump_src),
        .o_core_enable (o_core_enable),
        .o_step_flag   (o_step_flag),
        .o_step        (o_step),
        .o_state       (state)
    );

    program_loader program_loader_inst (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_start           (load_start),
        .i_rx_done         (i_rx_done),
        .i_rx_data         (i_rx_data),
        .o_im_write_enable (o_im_write_enable),
        .o_im_addr         (o_im_addr),
        .o_im_data         (o_im_data),
        .o_done            (load_done)
    );

    word_serializer word_serializer_inst (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_start          (dump_start),
        .i_src            (dump_src),
        .i_tx_done        (i_tx_done),
        .i_pc_value       (i_pc_value),
        .i_rb_data        (i_rb_data),
        .i_dm_data        (i_dm_data),
        .o_tx_start       (o_tx_start),
        .o_tx_data        (o_tx_data),
        .o_rb_read_enable (o_rb_read_enable),
        .o_rb_addr        (o_rb_addr),
        .o_dm_read_enable (o_dm_read_enable),
        .o_dm_du_flag     (o_dm_du_flag),
        .o_dm_addr        (o_dm_addr),
        .o_done           (dump_done)
    );

endmodule

//--- bench/tb_debug_unit.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module tb_debug_unit
    import debug_pkg::*;
();

    logic                     i_clock;
    logic                     i_reset;
    logic                     i_hlt;
    logic                     i_rx_done;
    byte_t                    i_rx_data;
    logic                     i_tx_done;
    word_t                    i_pc_value;
    word_t                    i_rb_data;
    word_t                    i_dm_data;
    logic                     o_tx_start;
    byte_t                    o_tx_data;
    logic                     o_im_write_enable;
    logic [`DU_IM_ADDR_W-1:0] o_im_addr;
    byte_t                    o_im_data;
    logic                     o_rb_read_enable;
    logic [`DU_RB_ADDR_W-1:0] o_rb_addr;
    logic                     o_dm_read_enable;
    logic                     o_dm_du_flag;
    logic [`DU_DM_ADDR_W-1:0] o_dm_addr;
    logic                     o_core_enable;
    logic                     o_step_flag;
    logic                     o_step;
    logic [`DU_STATE_W-1:0]   o_state;

    integer seed = 32'h3ec37e8f;
    int     errors = 0;
    int     errors_at_start;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     writes = 0;
    int     step_pulses = 0;
    word_t  rb_model [`DU_RB_DEPTH];
    word_t  dm_model [`DU_DM_DEPTH];
    byte_t  load_bytes [`DU_IM_BYTES];
    byte_t  tx_bytes [$];           // Bytes taken by the UART model
    byte_t  exp_bytes [$];

    debug_unit_top debug_unit_top_inst (.*);

    // Register bank and data memory answer in the same cycle
    assign i_rb_data = rb_model[o_rb_addr];
    assign i_dm_data = dm_model[o_dm_addr];

    initial begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    assert property (@(posedge i_clock) disable iff (i_reset)
                     (o_state == ST_STEP) |-> (o_step_flag && o_core_enable))
    else begin
        errors++;
        $display("o_step_flag or o_core_enable is low in the step state");
    end

    assert property (@(posedge i_clock) disable iff (i_reset)
                     (o_state == ST_RUN) |-> (o_core_enable && !o_step_flag))
    else begin
        errors++;
        $display("o_core_enable is low or o_step_flag is high in the run state");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected)
        else begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
        end
    endtask

    task automatic check_cond(input logic cond, input string what);
        assert (cond === 1'b1)
        else begin
            errors++;
            $display("%s", what);
        end
    endtask

    // Slow and uneven UART transmit side
    initial begin : uart_tx_model
        int delay;
        i_tx_done = 1'b0;
        forever begin
            @(negedge i_clock);
            if (o_tx_start === 1'b1) begin
                delay = 3 + {$random(seed)} % 6;
                repeat (delay - 1) @(negedge i_clock);
                tx_bytes.push_back(o_tx_data);
                @(posedge i_clock);
                i_tx_done <= 1'b1;
                @(posedge i_clock);
                i_tx_done <= 1'b0;
            end
        end
    end

    always @(negedge i_clock) begin
        if (!i_reset && o_im_write_enable) begin
            if (writes < `DU_IM_BYTES) begin
                check_value("o_im_addr", o_im_addr, writes);
                check_value("o_im_data", o_im_data, load_bytes[writes]);
            end else begin
                check_cond(1'b0, "write pulse after the last program byte");
            end
            writes++;
        end
        if (!i_reset && o_step)
            step_pulses++;
        // Read enables follow the dump in progress
        if (!i_reset && o_tx_start) begin
            check_cond(o_state inside {ST_DUMP_PC, ST_DUMP_RB, ST_DUMP_DM},
                       "o_tx_start is high outside a dump state");
            check_value("o_rb_read_enable", o_rb_read_enable, o_state == ST_DUMP_RB);
            check_value("o_dm_read_enable", o_dm_read_enable, o_state == ST_DUMP_DM);
            check_value("o_dm_du_flag", o_dm_du_flag, o_state == ST_DUMP_DM);
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic send_byte(input byte_t value);
        @(posedge i_clock);
        i_rx_done <= 1'b1;
        i_rx_data <= value;
        @(posedge i_clock);
        i_rx_done <= 1'b0;
    endtask

    task automatic wait_state(input state_e target, input int limit, input string what);
        int n;
        n = 0;
        @(negedge i_clock);
        while (o_state !== target && n < limit) begin
            @(negedge i_clock);
            n++;
        end
        if (o_state !== target)
            abort_on_timeout(what);
    endtask

    task automatic wait_tx_level(input logic level, input int limit, input string what);
        int n;
        n = 0;
        @(negedge i_clock);
        while (o_tx_start !== level && n < limit) begin
            @(negedge i_clock);
            n++;
        end
        if (o_tx_start !== level)
            abort_on_timeout(what);
    endtask

    // MSB first on the link
    task automatic expect_word(input word_t w);
        int k;
        for (k = `DU_BYTES_PER_WORD - 1; k >= 0; k--)
            exp_bytes.push_back(w[k*`DU_DATA_W +: `DU_DATA_W]);
    endtask

    task automatic compare_tx_bytes();
        int i;
        check_value("transmitted byte count", tx_bytes.size(), exp_bytes.size());
        for (i = 0; i < exp_bytes.size() && i < tx_bytes.size(); i++)
            check_value("o_tx_data", tx_bytes[i], exp_bytes[i]);
    endtask

    task automatic dump_from_idle(input command_e cmd);
        int i;
        tx_bytes.delete();
        exp_bytes.delete();
        case (cmd)
            CMD_SEND_PC: expect_word(i_pc_value);
            CMD_SEND_RB: for (i = 0; i < `DU_RB_DEPTH; i++) expect_word(rb_model[i]);
            default:     for (i = 0; i < `DU_DM_DEPTH; i++) expect_word(dm_model[i]);
        endcase
        send_byte(cmd);
        wait_tx_level(1'b1, 10, "o_tx_start to rise");
        wait_tx_level(1'b0, 4000, "the end of the dump");
        @(negedge i_clock);
        check_value("o_state", o_state, ST_IDLE);
        compare_tx_bytes();
    endtask

    task automatic send_ignored(input byte_t value, input state_e held);
        send_byte(value);
        repeat (3) begin
            @(negedge i_clock);
            check_value("o_state", o_state, held);
            check_value("o_tx_start", o_tx_start, 1'b0);
            check_value("o_core_enable", o_core_enable, 1'b0);
            check_value("o_im_write_enable", o_im_write_enable, 1'b0);
        end
    endtask

    task automatic load_program();
        int i;
        writes = 0;
        for (i = 0; i < `DU_IM_BYTES; i++)
            load_bytes[i] = byte_t'($random(seed));
        send_byte(CMD_WRITE_IM);
        for (i = 0; i < `DU_IM_BYTES; i++)
            send_byte(load_bytes[i]);
        wait_state(ST_READY, 10, "o_state READY after the program load");
        check_value("write pulse count", writes, `DU_IM_BYTES);
    endtask

    // Core stops one cycle after it sees the halt level
    task automatic halt_core();
        @(posedge i_clock);
        i_hlt <= 1'b1;
        @(negedge i_clock);
        check_value("o_core_enable", o_core_enable, 1'b1);
        @(negedge i_clock);
        check_value("o_core_enable", o_core_enable, 1'b0);
        check_value("o_step_flag", o_step_flag, 1'b0);
        check_value("o_state", o_state, ST_IDLE);
        @(posedge i_clock);
        i_hlt <= 1'b0;
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %-26s ok", name);
        end else begin
            tests_failed++;
            $display("test %-26s failed, %0d errors", name, errors - errors_at_start);
        end
    endtask

    initial begin : stimulus
        int i;
        int hold;
        i_reset    = 1'b1;
        i_hlt      = 1'b0;
        i_rx_done  = 1'b0;
        i_rx_data  = '0;
        i_pc_value = $random(seed);
        for (i = 0; i < `DU_RB_DEPTH; i++)
            rb_model[i] = $random(seed);
        for (i = 0; i < `DU_DM_DEPTH; i++)
            dm_model[i] = $random(seed);
        repeat (4) @(posedge i_clock);
        i_reset <= 1'b0;

        start_test();
        @(negedge i_clock);
        check_value("o_tx_start", o_tx_start, 1'b0);
        check_value("o_im_write_enable", o_im_write_enable, 1'b0);
        check_value("o_core_enable", o_core_enable, 1'b0);
        check_value("o_step_flag", o_step_flag, 1'b0);
        check_value("o_step", o_step, 1'b0);
        check_value("o_rb_read_enable", o_rb_read_enable, 1'b0);
        check_value("o_dm_read_enable", o_dm_read_enable, 1'b0);
        check_value("o_dm_du_flag", o_dm_du_flag, 1'b0);
        check_value("o_state", o_state, ST_IDLE);
        check_value("o_im_addr", o_im_addr, 0);
        check_value("o_rb_addr", o_rb_addr, 0);
        check_value("o_dm_addr", o_dm_addr, 0);
        close_test("reset values");

        start_test();
        dump_from_idle(CMD_SEND_PC);
        dump_from_idle(CMD_SEND_RB);
        dump_from_idle(CMD_SEND_DM);
        close_test("dumps from idle");

        start_test();
        send_ignored(CMD_START, ST_IDLE);
        send_ignored(CMD_STEP, ST_IDLE);
        send_ignored(CMD_CONTINUE, ST_IDLE);
        send_ignored(8'hc3, ST_IDLE);
        close_test("ignored bytes in idle");

        start_test();
        load_program();
        close_test("program load");

        start_test();
        send_ignored(CMD_SEND_PC, ST_READY);
        send_ignored(CMD_WRITE_IM, ST_READY);
        send_ignored(CMD_STEP, ST_READY);
        send_ignored(CMD_CONTINUE, ST_READY);
        close_test("ignored bytes in ready");

        start_test();
        send_byte(CMD_START);
        hold = 4 + {$random(seed)} % 16;
        repeat (hold) begin
            @(negedge i_clock);
            check_value("o_state", o_state, ST_RUN);
            check_value("o_core_enable", o_core_enable, 1'b1);
        end
        halt_core();
        close_test("run until halt");

        start_test();
        load_program();
        send_byte(CMD_STEP_BY_STEP);
        @(negedge i_clock);
        check_value("o_state", o_state, ST_STEP);
        check_value("o_step_flag", o_step_flag, 1'b1);
        tx_bytes.delete();
        exp_bytes.delete();
        step_pulses = 0;
        expect_word(i_pc_value);    // PC, then DM, then RB
        for (i = 0; i < `DU_DM_DEPTH; i++)
            expect_word(dm_model[i]);
        for (i = 0; i < `DU_RB_DEPTH; i++)
            expect_word(rb_model[i]);
        send_byte(CMD_STEP);
        wait_state(ST_STEP, 6000, "o_state STEP after the step dumps");
        check_value("o_step pulse count", step_pulses, 1);
        check_value("o_step_flag", o_step_flag, 1'b1);
        check_value("o_core_enable", o_core_enable, 1'b1);
        compare_tx_bytes();
        close_test("single step with dumps");

        start_test();
        send_byte(CMD_CONTINUE);
        @(negedge i_clock);
        check_value("o_state", o_state, ST_RUN);
        check_value("o_core_enable", o_core_enable, 1'b1);
        check_value("o_step_flag", o_step_flag, 1'b0);
        halt_core();
        close_test("continue from step");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+common
common/debug_pkg.sv
design/program_loader.sv
debug_unit/command_fsm.sv
debug_unit/word_serializer.sv
design/debug_unit_top.sv
bench/tb_debug_unit.sv

//--- Bender.yml
package:
  name: debug_unit

sources:
  - include_dirs:
      - common
    files:
      - common/debug_pkg.sv
      - design/program_loader.sv
      - debug_unit/command_fsm.sv
      - debug_unit/word_serializer.sv
      - design/debug_unit_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - bench/tb_debug_unit.sv
